/* vlog.f */
+incdir+sim
hdl/ldqPkg.sv
hdl/ldqEntry.sv
hdl/ldqArray.sv
hdl/ldqOccupancy.sv
hdl/ldq.sv
sim/ldqTb.sv

/* sim/ldqRefModel.svh */
`ifndef LDQ_REF_MODEL_SVH
`define LDQ_REF_MODEL_SVH

// model state with one slot per queue entry
logic                  mFree   [ENTRY_COUNT];
logic                  mThread [ENTRY_COUNT];
logic                  mConfl  [ENTRY_COUNT];
logic [IID_WIDTH-1:0]  mIid    [ENTRY_COUNT];
logic [LINE_WIDTH-1:0] mLine   [ENTRY_COUNT];
logic [BANK_COUNT-1:0] mBanks  [ENTRY_COUNT];
int                    mCnt    [2];

// a store conflicts with a load on the same line with a shared bank
function automatic logic storeHits(input logic [LINE_WIDTH-1:0] ldLine,
                                   input logic [BANK_COUNT-1:0] ldBanks,
                                   input logic [LINE_WIDTH-1:0] stLine,
                                   input logic [BANK_COUNT-1:0] stBanks);
  return (ldLine == stLine) && ((ldBanks & stBanks) != '0);
endfunction

function automatic logic idLive(input logic [IID_WIDTH-1:0] id);
  logic live;
  live = 1'b0;
  for (int i = 0; i < ENTRY_COUNT; i++) begin
    if (!mFree[i] && mIid[i] == id) begin
      live = 1'b1;
    end
  end
  return live;
endfunction

// expected {retHit, retConfl, doStall} for the current cycle
function automatic logic [2:0] expectOut();
  logic hit;
  logic confl;
  logic stall;
  hit = 1'b0;
  confl = 1'b0;
  stall = (mCnt[0] + mCnt[1]) >= STALL_LEVEL;
  for (int i = 0; i < ENTRY_COUNT; i++) begin
    if (retEn && !except && !mFree[i] && mIid[i] == retIid) begin
      hit = 1'b1;
      confl = mConfl[i];
    end
  end
  return {hit, confl, stall};
endfunction

// advance the model across one rising edge
task automatic stepModel();
  logic stall;
  logic allocGo;
  logic retThr;
  int   slot;
  int   hitIdx;
  if (rst) begin
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      mFree[i] = 1'b1;
      mThread[i] = 1'b0;
      mConfl[i] = 1'b0;
    end
    mCnt[0] = 0;
    mCnt[1] = 0;
  end else begin
    stall = (mCnt[0] + mCnt[1]) >= STALL_LEVEL;
    allocGo = newEn && !stall && !except;
    slot = -1;
    hitIdx = -1;
    retThr = 1'b0;
    for (int i = ENTRY_COUNT - 1; i >= 0; i--) begin
      if (mFree[i]) begin
        slot = i;
      end
    end
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (retEn && !except && !mFree[i] && mIid[i] == retIid) begin
        hitIdx = i;
        retThr = mThread[i];
      end
    end
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (except && mThread[i] == exceptThread) begin
        mFree[i] = 1'b1;
      end else if (allocGo && i == slot) begin
        mFree[i] = 1'b0;
        mThread[i] = newThread;
        mIid[i] = newIid;
        mLine[i] = newLine;
        mBanks[i] = newBanks;
        mConfl[i] = chkEn && storeHits(newLine, newBanks, chkLine, chkBanks);
      end else if (!mFree[i]) begin
        if (chkEn && storeHits(mLine[i], mBanks[i], chkLine, chkBanks)) begin
          mConfl[i] = 1'b1;
        end
        if (i == hitIdx) begin
          mFree[i] = 1'b1;
        end
      end
    end
    for (int t = 0; t < 2; t++) begin
      if (except && exceptThread == t) begin
        mCnt[t] = 0;
      end else begin
        mCnt[t] = mCnt[t] + int'(allocGo && newThread == t) - int'(hitIdx >= 0 && retThr == t);
      end
    end
  end
endtask

`endif

/* sim/ldqTb.sv */
`timescale 1ns/1ps

module ldqTb
  import ldqPkg::*;
();

  localparam int DIR_CYCLES = 100;
  localparam int RAND_CYCLES = 2000;
  localparam int CLK_PERIOD = 20;
  localparam logic [31:0] SEED = 32'ha0d0eb7e;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  newEn;
  logic [LINE_WIDTH-1:0] newLine;
  logic [BANK_COUNT-1:0] newBanks;
  logic [IID_WIDTH-1:0]  newIid;
  logic                  newThread;
  logic                  chkEn;
  logic [LINE_WIDTH-1:0] chkLine;
  logic [BANK_COUNT-1:0] chkBanks;
  logic                  retEn;
  logic [IID_WIDTH-1:0]  retIid;
  logic                  except;
  logic                  exceptThread;
  logic                  doStall;
  logic                  retHit;
  logic                  retConfl;
  logic [IID_WIDTH-1:0]  nextIid;

  `include "ldqRefModel.svh"

  ldq dut0 (
    .clk          (clk),
    .rst          (rst),
    .newEn        (newEn),
    .newLine      (newLine),
    .newBanks     (newBanks),
    .newIid       (newIid),
    .newThread    (newThread),
    .chkEn        (chkEn),
    .chkLine      (chkLine),
    .chkBanks     (chkBanks),
    .retEn        (retEn),
    .retIid       (retIid),
    .except       (except),
    .exceptThread (exceptThread),
    .doStall      (doStall),
    .retHit       (retHit),
    .retConfl     (retConfl)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic checkVal(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // strobes last one cycle unless set again
  task automatic nextCycle();
    @(posedge clk);
    #2;
    newEn = 1'b0;
    chkEn = 1'b0;
    retEn = 1'b0;
    except = 1'b0;
  endtask

  task automatic setAlloc(input logic thr, input logic [IID_WIDTH-1:0] iid,
                          input logic [LINE_WIDTH-1:0] line,
                          input logic [BANK_COUNT-1:0] banks);
    newEn = 1'b1;
    newThread = thr;
    newIid = iid;
    newLine = line;
    newBanks = banks;
  endtask

  task automatic setCheck(input logic [LINE_WIDTH-1:0] line,
                          input logic [BANK_COUNT-1:0] banks);
    chkEn = 1'b1;
    chkLine = line;
    chkBanks = banks;
  endtask

  task automatic setRetire(input logic [IID_WIDTH-1:0] iid);
    retEn = 1'b1;
    retIid = iid;
  endtask

  task automatic setFlush(input logic thr);
    except = 1'b1;
    exceptThread = thr;
  endtask

  task automatic allocLoad(input logic thr, input logic [IID_WIDTH-1:0] iid,
                           input logic [LINE_WIDTH-1:0] line,
                           input logic [BANK_COUNT-1:0] banks);
    nextCycle();
    setAlloc(thr, iid, line, banks);
  endtask

  task automatic retireExpect(input logic [IID_WIDTH-1:0] iid, input logic expHit,
                              input logic expConfl);
    nextCycle();
    setRetire(iid);
    #10;
    checkVal("retHit", expHit, retHit);
    checkVal("retConfl", expConfl, retConfl);
  endtask

  task automatic stallExpect(input logic expStall);
    nextCycle();
    #10;
    checkVal("doStall", expStall, doStall);
  endtask

  // an id that no waiting load holds
  function automatic logic [IID_WIDTH-1:0] freshIid();
    logic [IID_WIDTH-1:0] id;
    id = nextIid;
    while (idLive(id)) begin
      id++;
    end
    nextIid = id + 1'b1;
    return id;
  endfunction

  function automatic logic [IID_WIDTH-1:0] pickRetireIid();
    int idx;
    idx = $urandom_range(ENTRY_COUNT - 1);
    if (!mFree[idx] && $urandom_range(3) != 0) begin
      return mIid[idx];
    end
    return IID_WIDTH'($urandom);
  endfunction

  // compare just before each rising edge, then step the model over it
  initial begin
    logic [2:0] expOut;
    forever begin
      @(posedge clk);
      #18;
      if (!rst) begin
        expOut = expectOut();
        checkVal("retHit", expOut[2], retHit);
        checkVal("retConfl", expOut[1], retConfl);
        checkVal("doStall", expOut[0], doStall);
      end
      stepModel();
    end
  end

  initial begin
    #((DIR_CYCLES + RAND_CYCLES + 100) * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    newEn = 1'b0;
    newLine = '0;
    newBanks = '0;
    newIid = '0;
    newThread = 1'b0;
    chkEn = 1'b0;
    chkLine = '0;
    chkBanks = '0;
    retEn = 1'b0;
    retIid = '0;
    except = 1'b0;
    exceptThread = 1'b0;
    nextIid = 6'd32;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    // allocate then retire twice
    allocLoad(1'b0, 6'd1, 16'h0010, 8'h01);
    retireExpect(6'd1, 1'b1, 1'b0);
    retireExpect(6'd1, 1'b0, 1'b0);

    // overlapping, disjoint and foreign-line stores
    allocLoad(1'b0, 6'd2, 16'h0020, 8'h0c);
    allocLoad(1'b1, 6'd3, 16'h0021, 8'h0c);
    allocLoad(1'b0, 6'd4, 16'h0022, 8'h0c);
    nextCycle();
    setCheck(16'h0020, 8'h04);
    nextCycle();
    setCheck(16'h0021, 8'h30);
    nextCycle();
    setCheck(16'h0099, 8'h0c);
    retireExpect(6'd2, 1'b1, 1'b1);
    retireExpect(6'd3, 1'b1, 1'b0);
    retireExpect(6'd4, 1'b1, 1'b0);

    // store checked in the allocation cycle
    allocLoad(1'b1, 6'd5, 16'h0030, 8'h80);
    setCheck(16'h0030, 8'h81);
    allocLoad(1'b1, 6'd6, 16'h0031, 8'h80);
    setCheck(16'h0031, 8'h01);
    retireExpect(6'd5, 1'b1, 1'b1);
    retireExpect(6'd6, 1'b1, 1'b0);

    // flush of thread 0 leaves thread 1 alone
    allocLoad(1'b0, 6'd10, 16'h0040, 8'h01);
    allocLoad(1'b1, 6'd12, 16'h0041, 8'h01);
    allocLoad(1'b0, 6'd11, 16'h0042, 8'h01);
    allocLoad(1'b1, 6'd13, 16'h0043, 8'h01);
    nextCycle();
    setFlush(1'b0);
    retireExpect(6'd10, 1'b0, 1'b0);
    retireExpect(6'd11, 1'b0, 1'b0);
    retireExpect(6'd12, 1'b1, 1'b0);
    retireExpect(6'd13, 1'b1, 1'b0);
    stallExpect(1'b0);

    // fill to the stall level
    for (int i = 0; i < STALL_LEVEL; i++) begin
      allocLoad(1'(i % 2), 6'(20 + i), 16'h0050 + 16'(i), 8'h01);
    end
    stallExpect(1'b1);
    allocLoad(1'b0, 6'd28, 16'h0060, 8'h01);
    retireExpect(6'd28, 1'b0, 1'b0);
    retireExpect(6'd20, 1'b1, 1'b0);
    stallExpect(1'b0);
    allocLoad(1'b1, 6'd29, 16'h0061, 8'h02);
    retireExpect(6'd29, 1'b1, 1'b0);
    nextCycle();
    setFlush(1'b0);
    nextCycle();
    setFlush(1'b1);

    // random mix over a small line range
    for (int c = 0; c < RAND_CYCLES; c++) begin
      nextCycle();
      if ($urandom_range(99) < 45) begin
        setAlloc(1'($urandom_range(1)), freshIid(), 16'($urandom_range(3)), 8'($urandom));
      end
      if ($urandom_range(99) < 30) begin
        setCheck(16'($urandom_range(3)), 8'($urandom));
      end
      if ($urandom_range(99) < 35) begin
        setRetire(pickRetireIid());
      end
      if ($urandom_range(99) < 2) begin
        setFlush(1'($urandom_range(1)));
      end
    end
    nextCycle();
    nextCycle();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* hdl/ldq.sv */
`timescale 1ns/1ps

module ldq
  import ldqPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  newEn,
  input  logic [LINE_WIDTH-1:0] newLine,
  input  logic [BANK_COUNT-1:0] newBanks,
  input  logic [IID_WIDTH-1:0]  newIid,
  input  logic                  newThread,
  input  logic                  chkEn,
  input  logic [LINE_WIDTH-1:0] chkLine,
  input  logic [BANK_COUNT-1:0] chkBanks,
  input  logic                  retEn,
  input  logic [IID_WIDTH-1:0]  retIid,
  input  logic                  except,
  input  logic                  exceptThread,
  output logic                  doStall,
  output logic                  retHit,
  output logic                  retConfl
);

  logic allocGo;
  logic retGo;
  logic retFreed;
  logic retThread;

  ldqArray arr0 (
    .clk          (clk),
    .rst          (rst),
    .allocGo      (allocGo),
    .newLine      (newLine),
    .newBanks     (newBanks),
    .newIid       (newIid),
    .newThread    (newThread),
    .chkEn        (chkEn),
    .chkLine      (chkLine),
    .chkBanks     (chkBanks),
    .retGo        (retGo),
    .retIid       (retIid),
    .except       (except),
    .exceptThread (exceptThread),
    .retFreed     (retFreed),
    .retThread    (retThread),
    .retConfl     (retConfl)
  );

  ldqOccupancy occ0 (
    .clk          (clk),
    .rst          (rst),
    .newEn        (newEn),
    .newThread    (newThread),
    .retEn        (retEn),
    .retFreed     (retFreed),
    .retThread    (retThread),
    .except       (except),
    .exceptThread (exceptThread),
    .allocGo      (allocGo),
    .retGo        (retGo),
    .doStall      (doStall)
  );

  // a retire hits when some valid entry held the id
  assign retHit = retFreed;

endmodule

/* hdl/ldqOccupancy.sv */
`timescale 1ns/1ps

module ldqOccupancy
  import ldqPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic newEn,
  input  logic newThread,
  input  logic retEn,
  input  logic retFreed,
  input  logic retThread,
  input  logic except,
  input  logic exceptThread,
  output logic allocGo,
  output logic retGo,
  output logic doStall
);

  logic [CNT_WIDTH-1:0] cnt [2];
  logic [CNT_WIDTH:0]   total;

  assign total = cnt[0] + cnt[1];
  assign doStall = (total >= (CNT_WIDTH + 1)'(STALL_LEVEL));

  // flush cycle blocks both allocate and retire
  assign allocGo = newEn && !doStall && !except;
  assign retGo = retEn && !except;

  for (genvar t = 0; t < 2; t++) begin : gCnt
    logic inc;
    logic dec;
    logic clr;

    assign inc = allocGo && (newThread == 1'(t));
    assign dec = retFreed && (retThread == 1'(t));
    assign clr = except && (exceptThread == 1'(t));

    always_ff @(posedge clk) begin
      if (rst) begin
        cnt[t] <= '0;
      end else if (clr) begin
        cnt[t] <= '0;
      end else begin
        // up and down together leave it unchanged
        cnt[t] <= cnt[t] + CNT_WIDTH'(inc) - CNT_WIDTH'(dec);
      end
    end
  end

endmodule

/* hdl/ldqArray.sv */
`timescale 1ns/1ps

module ldqArray
  import ldqPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  allocGo,
  input  logic [LINE_WIDTH-1:0] newLine,
  input  logic [BANK_COUNT-1:0] newBanks,
  input  logic [IID_WIDTH-1:0]  newIid,
  input  logic                  newThread,
  input  logic                  chkEn,
  input  logic [LINE_WIDTH-1:0] chkLine,
  input  logic [BANK_COUNT-1:0] chkBanks,
  input  logic                  retGo,
  input  logic [IID_WIDTH-1:0]  retIid,
  input  logic                  except,
  input  logic                  exceptThread,
  output logic                  retFreed,
  output logic                  retThread,
  output logic                  retConfl
);

  logic [ENTRY_COUNT-1:0]     freeVec;
  logic [ENTRY_COUNT-1:0]     threadVec;
  logic [ENTRY_COUNT-1:0]     retMatchVec;
  logic [ENTRY_COUNT-1:0]     conflVec;
  logic [ENTRY_COUNT-1:0]     loadVec;
  logic [ENTRY_IDX_WIDTH-1:0] firstIdx;
  logic                       anyFree;
  logic                       newConfl;

  // lowest numbered free entry
  always_comb begin
    firstIdx = '0;
    anyFree = 1'b0;
    for (int i = ENTRY_COUNT - 1; i >= 0; i--) begin
      if (freeVec[i]) begin
        firstIdx = ENTRY_IDX_WIDTH'(i);
        anyFree = 1'b1;
      end
    end
  end

  always_comb begin
    loadVec = '0;
    if (allocGo && anyFree) begin
      loadVec[firstIdx] = 1'b1;
    end
  end

  // a store checked in the allocation cycle marks the new load too
  assign newConfl = chkEn && addrBankMatch(newLine, chkLine, newBanks, chkBanks);

  for (genvar e = 0; e < ENTRY_COUNT; e++) begin : gEntry
    ldqEntry entry (
      .clk          (clk),
      .rst          (rst),
      .load         (loadVec[e]),
      .loadConfl    (newConfl),
      .newLine      (newLine),
      .newBanks     (newBanks),
      .newIid       (newIid),
      .newThread    (newThread),
      .chkEn        (chkEn),
      .chkLine      (chkLine),
      .chkBanks     (chkBanks),
      .retGo        (retGo),
      .retIid       (retIid),
      .except       (except),
      .exceptThread (exceptThread),
      .free         (freeVec[e]),
      .thread       (threadVec[e]),
      .retMatch     (retMatchVec[e]),
      .confl        (conflVec[e])
    );
  end

  // ids are unique, so at most one entry matches
  assign retFreed = |retMatchVec;
  assign retThread = |(retMatchVec & threadVec);
  assign retConfl = |(retMatchVec & conflVec);

endmodule

/* hdl/ldqEntry.sv */
`timescale 1ns/1ps

module ldqEntry
  import ldqPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic                  loadConfl,
  input  logic [LINE_WIDTH-1:0] newLine,
  input  logic [BANK_COUNT-1:0] newBanks,
  input  logic [IID_WIDTH-1:0]  newIid,
  input  logic                  newThread,
  input  logic                  chkEn,
  input  logic [LINE_WIDTH-1:0] chkLine,
  input  logic [BANK_COUNT-1:0] chkBanks,
  input  logic                  retGo,
  input  logic [IID_WIDTH-1:0]  retIid,
  input  logic                  except,
  input  logic                  exceptThread,
  output logic                  free,
  output logic                  thread,
  output logic                  retMatch,
  output logic                  confl
);

  logic [LINE_WIDTH-1:0] line;
  logic [BANK_COUNT-1:0] banks;
  logic [IID_WIDTH-1:0]  iid;
  logic                  chkHit;
  logic                  flushHit;

  // store check against the held load
  assign chkHit = chkEn && !free && addrBankMatch(line, chkLine, banks, chkBanks);

  assign flushHit = except && (exceptThread == thread);

  assign retMatch = retGo && !free && (retIid == iid);

  always_ff @(posedge clk) begin
    if (load) begin
      line <= newLine;
      banks <= newBanks;
      iid <= newIid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      free <= 1'b1;
      thread <= 1'b0;
      confl <= 1'b0;
    end else if (flushHit) begin
      free <= 1'b1;
    end else if (load) begin
      free <= 1'b0;
      thread <= newThread;
      confl <= loadConfl;
    end else begin
      if (retMatch) begin
        free <= 1'b1;
      end
      // sticky until the entry is reused
      confl <= confl || chkHit;
    end
  end

endmodule

/* hdl/ldqPkg.sv */
package ldqPkg;

  // queue geometry
  localparam int ENTRY_COUNT = 8;
  localparam int ENTRY_IDX_WIDTH = 3;

  // load and store descriptors
  localparam int IID_WIDTH = 6;
  localparam int LINE_WIDTH = 16;
  localparam int BANK_COUNT = 8;

  // per-thread occupancy
  localparam int CNT_WIDTH = 4;
  localparam int STALL_LEVEL = ENTRY_COUNT;

  // same line and at least one shared bank
  function automatic logic addrBankMatch(
    input logic [LINE_WIDTH-1:0] lineA,
    input logic [LINE_WIDTH-1:0] lineB,
    input logic [BANK_COUNT-1:0] banksA,
    input logic [BANK_COUNT-1:0] banksB
  );
    logic lineEq;
    logic bankHit;
    lineEq = (lineA == lineB);
    bankHit = |(banksA & banksB);
    return lineEq && bankHit;
  endfunction

endpackage
